/* common/lsu_fwd_pkg.sv */
// shared widths, opcode/size enums and byte-window helpers for the lsu forwarding blocks
package lsu_fwd_pkg;

   parameter int ADDR_W         = 32;
   parameter int DATA_W         = 32;
   parameter int BYTES_PER_WORD = 4;

   // defaults picked up by the top level
   parameter int DEF_SB_DEPTH     = 4;
   parameter int DEF_INIT_CREDITS = 2;

   typedef enum logic [1:0] {
      OP_NONE  = 2'd0,
      OP_LOAD  = 2'd1,
      OP_STORE = 2'd2
   } lsu_op_e;

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } lsu_size_e;

   typedef logic [2*BYTES_PER_WORD-1:0] window_be_t;   // lo word in [3:0], hi word in [7:4]
   typedef logic [2*DATA_W-1:0]         window_data_t;

   function automatic logic [BYTES_PER_WORD-1:0] size_be(input lsu_size_e sz);
      case (sz)
         SZ_BYTE: return 4'b0001;
         SZ_HALF: return 4'b0011;
         SZ_WORD: return 4'b1111;
         default: return 4'b0000;
      endcase
   endfunction

   function automatic window_be_t window_be(input logic [ADDR_W-1:0] a, input lsu_size_e sz);
      return {{BYTES_PER_WORD{1'b0}}, size_be(sz)} << a[1:0];
   endfunction

   function automatic window_data_t window_data(input logic [ADDR_W-1:0] a,
                                                input logic [DATA_W-1:0] d);
      return {{DATA_W{1'b0}}, d} << {a[1:0], 3'b000};
   endfunction

   // ********************
   // lo/hi word match of one store against the probing load
   // result is in the load's window, data is zero where no byte hit
   function automatic void window_match(input  logic [ADDR_W-1:0] ld_addr,
                                        input  lsu_size_e         ld_size,
                                        input  logic [ADDR_W-1:0] st_addr,
                                        input  lsu_size_e         st_size,
                                        input  logic [DATA_W-1:0] st_data,
                                        output window_be_t        hit,
                                        output window_data_t      data);
      logic [ADDR_W-3:0] ld_lo;
      logic [ADDR_W-3:0] ld_hi;
      logic [ADDR_W-3:0] st_lo;
      logic [ADDR_W-3:0] st_hi;
      window_be_t        lb;
      window_be_t        sb;
      window_data_t      sd;
      logic              lo_lo, lo_hi, hi_lo, hi_hi;
      ld_lo = ld_addr[ADDR_W-1:2];
      ld_hi = ld_lo + 1'b1;            // hi bytes only enabled when the access crosses
      st_lo = st_addr[ADDR_W-1:2];
      st_hi = st_lo + 1'b1;
      lb    = window_be(ld_addr, ld_size);
      sb    = window_be(st_addr, st_size);
      sd    = window_data(st_addr, st_data);
      lo_lo = (ld_lo == st_lo);
      lo_hi = (ld_lo == st_hi);
      hi_lo = (ld_hi == st_lo);
      hi_hi = (ld_hi == st_hi);
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         hit[b] = lb[b] & ((lo_lo & sb[b]) | (lo_hi & sb[BYTES_PER_WORD+b]));
         hit[BYTES_PER_WORD+b] = lb[BYTES_PER_WORD+b] &
                                 ((hi_lo & sb[b]) | (hi_hi & sb[BYTES_PER_WORD+b]));
         data[8*b +: 8] = ~hit[b]  ? 8'h00 :
                          (lo_lo & sb[b]) ? sd[8*b +: 8] : sd[DATA_W+8*b +: 8];
         data[DATA_W+8*b +: 8] = ~hit[BYTES_PER_WORD+b] ? 8'h00 :
                                 (hi_lo & sb[b]) ? sd[8*b +: 8] : sd[DATA_W+8*b +: 8];
      end
   endfunction

endpackage

/* rtl/pipe_fwd.sv */
// dc3..dc5 store stages and byte-wise forwarding match against the load probing in dc2
`timescale 1ns/1ps

module pipe_fwd (
   input  logic                             clk,
   input  logic                             rst_n,
   input  lsu_fwd_pkg::lsu_op_e             op,
   input  logic [lsu_fwd_pkg::ADDR_W-1:0]   addr,
   input  lsu_fwd_pkg::lsu_size_e           size,
   input  logic [lsu_fwd_pkg::DATA_W-1:0]   st_data,
   output lsu_fwd_pkg::window_be_t          pipe_hit_be,
   output lsu_fwd_pkg::window_data_t        pipe_hit_data,
   output logic                             dc5_st_valid,
   output logic [lsu_fwd_pkg::ADDR_W-1:0]   dc5_addr,
   output lsu_fwd_pkg::lsu_size_e           dc5_size,
   output logic [lsu_fwd_pkg::DATA_W-1:0]   dc5_data,
   output logic [1:0]                       stage_st_count
);
   import lsu_fwd_pkg::*;

   localparam int NSTG = 3;          // index 0 is dc3, 2 is dc5

   logic                stg_v    [NSTG];
   logic [ADDR_W-1:0]   stg_addr [NSTG];
   lsu_size_e           stg_size [NSTG];
   logic [DATA_W-1:0]   stg_data [NSTG];

   // ********************
   // stage registers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int s = 0; s < NSTG; s++) begin
            stg_v[s] <= 1'b0;
         end
      end else begin
         stg_v[0] <= (op == OP_STORE);
         for (int s = 1; s < NSTG; s++) begin
            stg_v[s] <= stg_v[s-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      stg_addr[0] <= addr;
      stg_size[0] <= size;
      stg_data[0] <= st_data;
      for (int s = 1; s < NSTG; s++) begin
         stg_addr[s] <= stg_addr[s-1];
         stg_size[s] <= stg_size[s-1];
         stg_data[s] <= stg_data[s-1];
      end
   end

   // ********************
   // match, walk oldest to youngest so dc3 wins per byte
   always_comb begin
      window_be_t   h;
      window_data_t d;
      pipe_hit_be   = '0;
      pipe_hit_data = '0;
      for (int s = NSTG-1; s >= 0; s--) begin
         window_match(addr, size, stg_addr[s], stg_size[s], stg_data[s], h, d);
         h = h & {(2*BYTES_PER_WORD){stg_v[s] & (op == OP_LOAD)}};
         for (int b = 0; b < 2*BYTES_PER_WORD; b++) begin
            if (h[b]) begin
               pipe_hit_data[8*b +: 8] = d[8*b +: 8];   // younger overrides
            end
         end
         pipe_hit_be = pipe_hit_be | h;
      end
   end

   assign dc5_st_valid   = stg_v[NSTG-1];
   assign dc5_addr       = stg_addr[NSTG-1];
   assign dc5_size       = stg_size[NSTG-1];
   assign dc5_data       = stg_data[NSTG-1];

   // stores still in flight, not yet holding a buffer entry
   assign stage_st_count = {1'b0, stg_v[0]} + {1'b0, stg_v[1]} + {1'b0, stg_v[2]};

endmodule

/* store_buf/store_buf.sv */
// committed-store FIFO with forwarding lookup and credit-based drain toward memory
`timescale 1ns/1ps

module store_buf #(
   parameter int SB_DEPTH     = lsu_fwd_pkg::DEF_SB_DEPTH,
   parameter int INIT_CREDITS = lsu_fwd_pkg::DEF_INIT_CREDITS
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  lsu_fwd_pkg::lsu_op_e             op,
   input  logic [lsu_fwd_pkg::ADDR_W-1:0]   addr,
   input  lsu_fwd_pkg::lsu_size_e           size,
   input  logic                             dc5_st_valid,
   input  logic [lsu_fwd_pkg::ADDR_W-1:0]   dc5_addr,
   input  lsu_fwd_pkg::lsu_size_e           dc5_size,
   input  logic [lsu_fwd_pkg::DATA_W-1:0]   dc5_data,
   input  logic [1:0]                       stage_st_count,
   input  logic                             mem_credit,
   output lsu_fwd_pkg::window_be_t          buf_hit_be,
   output lsu_fwd_pkg::window_data_t        buf_hit_data,
   output logic [$clog2(SB_DEPTH+1)-1:0]    st_room,
   output logic                             drain_valid,
   output logic [lsu_fwd_pkg::ADDR_W-1:0]   drain_addr,
   output lsu_fwd_pkg::lsu_size_e           drain_size,
   output logic [lsu_fwd_pkg::DATA_W-1:0]   drain_data
);
   import lsu_fwd_pkg::*;

   localparam int PTR_W  = (SB_DEPTH > 1) ? $clog2(SB_DEPTH) : 1;
   localparam int CNT_W  = $clog2(SB_DEPTH+1);
   localparam int CRED_W = $clog2(INIT_CREDITS+1) + 1;

   logic [ADDR_W-1:0]   sb_addr [SB_DEPTH];
   lsu_size_e           sb_size [SB_DEPTH];
   logic [DATA_W-1:0]   sb_data [SB_DEPTH];

   logic [PTR_W-1:0]    wr_ptr, rd_ptr;
   logic [CNT_W-1:0]    count;
   logic [CRED_W-1:0]   credits;

   // ********************
   // fifo control
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (dc5_st_valid) begin
            wr_ptr <= (wr_ptr == PTR_W'(SB_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         end
         if (drain_valid) begin
            rd_ptr <= (rd_ptr == PTR_W'(SB_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({dc5_st_valid, drain_valid})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;      // push and pop together
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (dc5_st_valid) begin
         sb_addr[wr_ptr] <= dc5_addr;
         sb_size[wr_ptr] <= dc5_size;
         sb_data[wr_ptr] <= dc5_data;
      end
   end

   // ********************
   // credit counter, saturates on spurious returns
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         credits <= CRED_W'(INIT_CREDITS);
      end else if (mem_credit && !drain_valid && (credits != '1)) begin
         credits <= credits + 1'b1;
      end else if (!mem_credit && drain_valid) begin
         credits <= credits - 1'b1;
      end
   end

   assign drain_valid = (count != '0) && (credits != '0);
   assign drain_addr  = sb_addr[rd_ptr];
   assign drain_size  = sb_size[rd_ptr];
   assign drain_data  = sb_data[rd_ptr];

   // free entries less the stores still in dc3..dc5
   always_comb begin
      int room;
      room    = SB_DEPTH - int'(count) - int'(stage_st_count);
      st_room = (room > 0) ? CNT_W'(room) : '0;
   end

   // ********************
   // lookup oldest to newest, newer entry overrides per byte
   always_comb begin
      window_be_t   h;
      window_data_t d;
      int           idx;
      buf_hit_be   = '0;
      buf_hit_data = '0;
      for (int k = 0; k < SB_DEPTH; k++) begin
         idx = (int'(rd_ptr) + k) % SB_DEPTH;
         window_match(addr, size, sb_addr[idx], sb_size[idx], sb_data[idx], h, d);
         h = h & {(2*BYTES_PER_WORD){(k < int'(count)) && (op == OP_LOAD)}};
         for (int b = 0; b < 2*BYTES_PER_WORD; b++) begin
            if (h[b]) begin
               buf_hit_data[8*b +: 8] = d[8*b +: 8];
            end
         end
         buf_hit_be = buf_hit_be | h;
      end
   end

endmodule

/* rtl/fwd_merge.sv */
// merges pipe and buffer forwarding hits, aligns them to the load and registers into dc3
`timescale 1ns/1ps

module fwd_merge (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  lsu_fwd_pkg::lsu_op_e                    op,
   input  logic [lsu_fwd_pkg::ADDR_W-1:0]          addr,
   input  lsu_fwd_pkg::lsu_size_e                  size,
   input  lsu_fwd_pkg::window_be_t                 pipe_hit_be,
   input  lsu_fwd_pkg::window_data_t               pipe_hit_data,
   input  lsu_fwd_pkg::window_be_t                 buf_hit_be,
   input  lsu_fwd_pkg::window_data_t               buf_hit_data,
   output logic                                    ld_valid,
   output logic [lsu_fwd_pkg::DATA_W-1:0]          ld_data,
   output logic [lsu_fwd_pkg::BYTES_PER_WORD-1:0]  ld_hit_bytes,
   output logic                                    ld_full_hit
);
   import lsu_fwd_pkg::*;

   window_be_t                  win_be, be_shift;
   window_data_t                win_data, data_shift;
   logic [BYTES_PER_WORD-1:0]   hit_dc2;
   logic                        full_hit_dc2;

   // pipe beats buffer per byte
   always_comb begin
      win_be = pipe_hit_be | buf_hit_be;
      for (int b = 0; b < 2*BYTES_PER_WORD; b++) begin
         win_data[8*b +: 8] = pipe_hit_be[b] ? pipe_hit_data[8*b +: 8] :
                              (buf_hit_data[8*b +: 8] & {8{buf_hit_be[b]}});
      end
   end

   // ********************
   // align window to the load offset
   assign data_shift = win_data >> {addr[1:0], 3'b000};
   assign be_shift   = win_be >> addr[1:0];
   assign hit_dc2    = be_shift[BYTES_PER_WORD-1:0];

   // every enabled byte of the load must be covered
   assign full_hit_dc2 = (op == OP_LOAD) && ((hit_dc2 | ~size_be(size)) == '1);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ld_valid    <= 1'b0;
         ld_full_hit <= 1'b0;
      end else begin
         ld_valid    <= (op == OP_LOAD);
         ld_full_hit <= full_hit_dc2;
      end
   end

   always_ff @(posedge clk) begin
      ld_data      <= data_shift[DATA_W-1:0];   // unhit bytes already zero
      ld_hit_bytes <= hit_dc2;
   end

endmodule

/* rtl/lsu_fwd_top.sv */
// top level of the store-to-load forwarding unit, connects pipe matcher, store buffer and merge
`timescale 1ns/1ps

module lsu_fwd_top #(
   parameter int SB_DEPTH     = lsu_fwd_pkg::DEF_SB_DEPTH,
   parameter int INIT_CREDITS = lsu_fwd_pkg::DEF_INIT_CREDITS
) (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  lsu_fwd_pkg::lsu_op_e                    op,
   input  logic [lsu_fwd_pkg::ADDR_W-1:0]          addr,
   input  lsu_fwd_pkg::lsu_size_e                  size,
   input  logic [lsu_fwd_pkg::DATA_W-1:0]          st_data,
   input  logic                                    mem_credit,
   output logic                                    ld_valid,
   output logic [lsu_fwd_pkg::DATA_W-1:0]          ld_data,
   output logic [lsu_fwd_pkg::BYTES_PER_WORD-1:0]  ld_hit_bytes,
   output logic                                    ld_full_hit,
   output logic [$clog2(SB_DEPTH+1)-1:0]           st_room,
   output logic                                    drain_valid,
   output logic [lsu_fwd_pkg::ADDR_W-1:0]          drain_addr,
   output lsu_fwd_pkg::lsu_size_e                  drain_size,
   output logic [lsu_fwd_pkg::DATA_W-1:0]          drain_data
);
   import lsu_fwd_pkg::*;

   window_be_t          pipe_hit_be, buf_hit_be;
   window_data_t        pipe_hit_data, buf_hit_data;
   logic                dc5_st_valid;
   logic [ADDR_W-1:0]   dc5_addr;
   lsu_size_e           dc5_size;
   logic [DATA_W-1:0]   dc5_data;
   logic [1:0]          stage_st_count;

   pipe_fwd i_pipe (
      .clk, .rst_n, .op, .addr, .size, .st_data,
      .pipe_hit_be, .pipe_hit_data,
      .dc5_st_valid, .dc5_addr, .dc5_size, .dc5_data,
      .stage_st_count
   );

   store_buf #(
      .SB_DEPTH     (SB_DEPTH),
      .INIT_CREDITS (INIT_CREDITS)
   ) i_sb (
      .clk, .rst_n, .op, .addr, .size,
      .dc5_st_valid, .dc5_addr, .dc5_size, .dc5_data,
      .stage_st_count, .mem_credit,
      .buf_hit_be, .buf_hit_data, .st_room,
      .drain_valid, .drain_addr, .drain_size, .drain_data
   );

   fwd_merge i_merge (
      .clk, .rst_n, .op, .addr, .size,
      .pipe_hit_be, .pipe_hit_data, .buf_hit_be, .buf_hit_data,
      .ld_valid, .ld_data, .ld_hit_bytes, .ld_full_hit
   );

endmodule

/* tests/tb_vectors.svh */
// stimulus and expected-result rows for the lsu forwarding testbench, included in its module body
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: op, addr, size, store data, exp ld_data, exp hit bytes, exp full hit,
//          credit enable, wait for an empty buffer before the row
task automatic fill_table();
   // ********************
   // credits withheld, only the two initial ones drain
   add_row(OP_STORE, 32'h00000100, SZ_WORD, 32'h11111111, 32'h0, 4'h0, 1'b0, 1'b0, 1'b1);
   add_row(OP_STORE, 32'h00000200, SZ_WORD, 32'h22222222, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
   add_row(OP_STORE, 32'h00000300, SZ_WORD, 32'h33333333, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
   add_row(OP_STORE, 32'h00000400, SZ_WORD, 32'h44444444, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
   add_row(OP_NONE,  32'h00000000, SZ_BYTE, 32'h00000000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
   add_row(OP_NONE,  32'h00000000, SZ_BYTE, 32'h00000000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
   add_row(OP_NONE,  32'h00000000, SZ_BYTE, 32'h00000000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
   // stores 3 and 4 are held in the buffer
   add_row(OP_LOAD,  32'h00000300, SZ_WORD, 32'h0, 32'h33333333, 4'hf, 1'b1, 1'b0, 1'b0);
   add_row(OP_LOAD,  32'h00000402, SZ_HALF, 32'h0, 32'h00004444, 4'h3, 1'b1, 1'b0, 1'b0);
   add_row(OP_LOAD,  32'h00000100, SZ_WORD, 32'h0, 32'h00000000, 4'h0, 1'b0, 1'b0, 1'b0);
   add_row(OP_LOAD,  32'h00000203, SZ_BYTE, 32'h0, 32'h00000000, 4'h0, 1'b0, 1'b0, 1'b0);
   add_row(OP_LOAD,  32'h000003fe, SZ_WORD, 32'h0, 32'h44440000, 4'hc, 1'b0, 1'b0, 1'b0);
   add_row(OP_NONE,  32'h00000000, SZ_BYTE, 32'h00000000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);

   // ********************
   // credits released, one store then loads from dc3, dc4 and dc5
   add_row(OP_STORE, 32'h00001300, SZ_WORD, 32'h0f1e2d3c, 32'h0, 4'h0, 1'b0, 1'b1, 1'b1);
   add_row(OP_LOAD,  32'h00001300, SZ_WORD, 32'h0, 32'h0f1e2d3c, 4'hf, 1'b1, 1'b1, 1'b0);
   add_row(OP_LOAD,  32'h00001302, SZ_HALF, 32'h0, 32'h00000f1e, 4'h3, 1'b1, 1'b1, 1'b0);
   add_row(OP_LOAD,  32'h00001301, SZ_BYTE, 32'h0, 32'h0000002d, 4'h1, 1'b1, 1'b1, 1'b0);

   // younger byte store in dc3 over an older word in dc4
   add_row(OP_STORE, 32'h00002000, SZ_WORD, 32'h12345678, 32'h0, 4'h0, 1'b0, 1'b1, 1'b1);
   add_row(OP_STORE, 32'h00002001, SZ_BYTE, 32'h000000ab, 32'h0, 4'h0, 1'b0, 1'b1, 1'b0);
   add_row(OP_LOAD,  32'h00002000, SZ_WORD, 32'h0, 32'h1234ab78, 4'hf, 1'b1, 1'b1, 1'b0);

   // younger word in dc3 over an older byte in dc5
   add_row(OP_STORE, 32'h00002102, SZ_BYTE, 32'h000000cd, 32'h0, 4'h0, 1'b0, 1'b1, 1'b1);
   add_row(OP_NONE,  32'h00000000, SZ_BYTE, 32'h00000000, 32'h0, 4'h0, 1'b0, 1'b1, 1'b0);
   add_row(OP_STORE, 32'h00002100, SZ_WORD, 32'hcafef00d, 32'h0, 4'h0, 1'b0, 1'b1, 1'b0);
   add_row(OP_LOAD,  32'h00002102, SZ_BYTE, 32'h0, 32'h000000fe, 4'h1, 1'b1, 1'b1, 1'b0);

   // ********************
   // word load crossing into the next word, partly covered
   add_row(OP_STORE, 32'h00003002, SZ_HALF, 32'h0000beef, 32'h0, 4'h0, 1'b0, 1'b1, 1'b1);
   add_row(OP_STORE, 32'h00003004, SZ_BYTE, 32'h00000077, 32'h0, 4'h0, 1'b0, 1'b1, 1'b0);
   add_row(OP_LOAD,  32'h00003002, SZ_WORD, 32'h0, 32'h0077beef, 4'h7, 1'b0, 1'b1, 1'b0);

   // crossing half store seen by a crossing word load
   add_row(OP_STORE, 32'h00003107, SZ_HALF, 32'h00001357, 32'h0, 4'h0, 1'b0, 1'b1, 1'b1);
   add_row(OP_LOAD,  32'h00003106, SZ_WORD, 32'h0, 32'h00135700, 4'h6, 1'b0, 1'b1, 1'b0);
   add_row(OP_NONE,  32'h00000000, SZ_BYTE, 32'h00000000, 32'h0, 4'h0, 1'b0, 1'b1, 1'b0);
endtask

`endif

/* tests/tb_lsu_fwd.sv */
// testbench for lsu_fwd_top that applies the vector table and checks loads and the drain order
`timescale 1ns/1ps

module tb_lsu_fwd;
   import lsu_fwd_pkg::*;

   localparam int SB_DEPTH     = DEF_SB_DEPTH;
   localparam int INIT_CREDITS = DEF_INIT_CREDITS;
   localparam int RESET_CYCLES = 16;

   typedef struct packed {
      lsu_op_e       op;
      logic [31:0]   addr;
      lsu_size_e     size;
      logic [31:0]   data;
      logic [31:0]   exp_data;
      logic [3:0]    exp_hit;
      logic          exp_full;
      logic          credit_en;
      logic          sync;       // wait until buffer and stages are empty
   } row_t;

   logic                            clk, rst_n, mem_credit;
   lsu_op_e                         op;
   logic [ADDR_W-1:0]               addr;
   lsu_size_e                       size;
   logic [DATA_W-1:0]               st_data;
   logic                            ld_valid, ld_full_hit, drain_valid;
   logic [DATA_W-1:0]               ld_data, drain_data;
   logic [BYTES_PER_WORD-1:0]       ld_hit_bytes;
   logic [$clog2(SB_DEPTH+1)-1:0]   st_room;
   logic [ADDR_W-1:0]               drain_addr;
   lsu_size_e                       drain_size;

   row_t          table_rows[$];
   logic [65:0]   drain_q[$];        // {addr, size, data} in store order
   row_t          pend_row;
   logic          pend_load;
   logic          credit_en_now;
   integer        seed = 32'he0332008;
   int            value_errs  = 0;
   int            other_errs  = 0;
   int            cycles      = 0;
   int            cycle_limit = 1000;
   int            drains_seen = 0;
   int            credits_seen = 0;

   lsu_fwd_top #(.SB_DEPTH(SB_DEPTH), .INIT_CREDITS(INIT_CREDITS)) i_dut (.*);

   task automatic add_row(input lsu_op_e o, input logic [31:0] a, input lsu_size_e s,
                          input logic [31:0] d, input logic [31:0] ed, input logic [3:0] eh,
                          input logic ef, input logic ce, input logic sy);
      row_t r;
      r = '{op: o, addr: a, size: s, data: d, exp_data: ed, exp_hit: eh,
            exp_full: ef, credit_en: ce, sync: sy};
      table_rows.push_back(r);
   endtask

   `include "tb_vectors.svh"

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ********************
   // per-cycle helpers
   task automatic check_result();
      assert (ld_valid == pend_load) else begin
         value_errs++;
         $display("ERR ld_valid: got %h expected %h", ld_valid, pend_load);
      end
      if (pend_load) begin
         assert (ld_data == pend_row.exp_data) else begin
            value_errs++;
            $display("ERR ld_data: addr %h got %h expected %h",
                     pend_row.addr, ld_data, pend_row.exp_data);
         end
         assert (ld_hit_bytes == pend_row.exp_hit) else begin
            value_errs++;
            $display("ERR ld_hit_bytes: addr %h got %h expected %h",
                     pend_row.addr, ld_hit_bytes, pend_row.exp_hit);
         end
         assert (ld_full_hit == pend_row.exp_full) else begin
            value_errs++;
            $display("ERR ld_full_hit: addr %h got %h expected %h",
                     pend_row.addr, ld_full_hit, pend_row.exp_full);
         end
      end
      pend_load = 1'b0;
   endtask

   task automatic next_cycle();
      int r;
      @(posedge clk);
      #2;
      r = $random(seed);
      mem_credit = credit_en_now & r[0];   // roughly every other cycle
      check_result();
   endtask

   task automatic drive_idle();
      op      = OP_NONE;
      addr    = '0;
      size    = SZ_BYTE;
      st_data = '0;
   endtask

   task automatic apply_row(input row_t r);
      if (r.op == OP_STORE) begin
         assert (st_room != '0) else begin
            other_errs++;
            $display("store issued while the store buffer reported no room");
         end
         drain_q.push_back({r.addr, r.size, r.data});
      end
      op        = r.op;
      addr      = r.addr;
      size      = r.size;
      st_data   = r.data;
      pend_load = (r.op == OP_LOAD);
      pend_row  = r;
   endtask

   // ********************
   // drain monitor sampled mid-cycle
   always @(negedge clk) begin
      logic [65:0] exp;
      if (rst_n) begin
         if (drain_valid) begin
            drains_seen++;
            assert (drains_seen <= INIT_CREDITS + credits_seen) else begin
               other_errs++;
               $display("drain issued without a credit available");
            end
            assert (drain_q.size() != 0) else begin
               other_errs++;
               $display("drain seen with no store outstanding");
            end
            if (drain_q.size() != 0) begin
               exp = drain_q.pop_front();
               assert (drain_addr == exp[65:34]) else begin
                  value_errs++;
                  $display("ERR drain_addr: got %h expected %h", drain_addr, exp[65:34]);
               end
               assert (drain_size == exp[33:32]) else begin
                  value_errs++;
                  $display("ERR drain_size: got %h expected %h", drain_size, exp[33:32]);
               end
               assert (drain_data == exp[31:0]) else begin
                  value_errs++;
                  $display("ERR drain_data: got %h expected %h", drain_data, exp[31:0]);
               end
            end
         end
         if (mem_credit) credits_seen++;   // usable from the next cycle on
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
         $display("Done: errors found");
         $finish;
      end
   end

   // ********************
   // main sequence
   initial begin
      row_t r;
      fill_table();
      cycle_limit   = table_rows.size() + RESET_CYCLES + 200;
      rst_n         = 1'b0;
      mem_credit    = 1'b0;
      credit_en_now = 1'b0;
      pend_load     = 1'b0;
      drive_idle();
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      rst_n = 1'b1;

      assert (int'(st_room) == SB_DEPTH) else begin
         value_errs++;
         $display("ERR st_room: got %h expected %h", st_room, SB_DEPTH);
      end
      assert (!drain_valid) else begin
         value_errs++;
         $display("ERR drain_valid: got %h expected 0", drain_valid);
      end
      assert (!ld_valid) else begin
         value_errs++;
         $display("ERR ld_valid: got %h expected 0", ld_valid);
      end

      for (int i = 0; i < table_rows.size(); i++) begin
         r = table_rows[i];
         credit_en_now = r.credit_en;
         next_cycle();
         if (r.sync) begin
            while (int'(st_room) != SB_DEPTH) begin
               drive_idle();
               next_cycle();
            end
         end
         apply_row(r);
      end

      // let the remaining stores drain
      credit_en_now = 1'b1;
      next_cycle();
      drive_idle();
      while (drain_q.size() != 0) begin
         next_cycle();
      end
      repeat (4) next_cycle();

      $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* sim.f */
+incdir+tests
common/lsu_fwd_pkg.sv
rtl/pipe_fwd.sv
store_buf/store_buf.sv
rtl/fwd_merge.sv
rtl/lsu_fwd_top.sv
tests/tb_lsu_fwd.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_lsu_fwd -Mdir obj_dir -o sim_lsu_fwd

out=$(./obj_dir/sim_lsu_fwd)
echo "$out"

if echo "$out" | grep -qxF "Done: no errors"; then
   exit 0
fi
exit 1
